//--- abs_cmp_pkg.sv
package abs_cmp_pkg;

  //////////////////////////////
  // beat geometry
  //////////////////////////////
  // 16-bit lanes per beat
  localparam int NUM_LANES = 8;
  localparam int LANE_W = 16;
  // interference estimate width
  localparam int THRESH_W = 64;

  //////////////////////////////
  // flow control
  //////////////////////////////
  // input buffer slots, also the source credits after reset
  localparam int DEPTH = 4;
  // buffer pointer index width
  localparam int PTR_W = $clog2(DEPTH);
  // downstream slots after reset
  localparam int OUT_CREDITS = 4;
  // beat stages ahead of the compare register
  localparam int CMP_LAT = 3;

  // one lane, raw two's complement
  typedef logic [LANE_W-1:0] lane_t;
  // magnitudes carry one growth bit
  typedef logic [LANE_W:0] mag16_t;
  typedef logic [2*LANE_W:0] mag32_t;
  typedef logic [THRESH_W-1:0] thresh_t;
  // one quiet flag per sample
  typedef logic [NUM_LANES-1:0] flags_t;
  // 0 to OUT_CREDITS
  typedef logic [2:0] credit_t;

  // lane interpretation of a beat
  typedef enum logic [1:0] {
    MODE_REAL16 = 2'd0,
    MODE_CPLX16 = 2'd1,
    MODE_CPLX32 = 2'd2
  } mode_e;

endpackage

//--- beat_if.sv
`timescale 1ns/1ns

// one popped beat, buffer to compare stage
interface beat_if;
  import abs_cmp_pkg::*;

  // registered pop strobe
  logic valid;
  mode_e mode;
  thresh_t thresh;
  lane_t [NUM_LANES-1:0] lanes;

  // buffer side
  modport src (
    output valid, mode, thresh, lanes
  );

  // compare side
  modport dst (
    input valid, mode, thresh, lanes
  );

endinterface

//--- beat_fifo.sv
`timescale 1ns/1ns

module beat_fifo (
  input  logic clk,
  input  logic rst_n,
  input  logic i_valid,
  input  abs_cmp_pkg::mode_e i_mode,
  input  abs_cmp_pkg::thresh_t i_thresh,
  input  abs_cmp_pkg::lane_t [abs_cmp_pkg::NUM_LANES-1:0] i_lanes,
  input  logic i_pop_ok,
  output logic o_popped,
  output logic o_in_credit,
  beat_if.src o_beat
);
  import abs_cmp_pkg::*;

  //////////////////////////////
  // storage
  //////////////////////////////
  mode_e mode_mem [DEPTH];
  thresh_t thresh_mem [DEPTH];
  lane_t [NUM_LANES-1:0] lanes_mem [DEPTH];

  // extra msb tells full from empty
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic full;
  logic empty;
  logic wr_en;
  logic pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  // a write into a full buffer is dropped here, never overwrites
  assign wr_en = i_valid && !full;
  // pointers are registered, so a fresh beat pops one edge later at the earliest
  assign pop = !empty && i_pop_ok;
  assign o_popped = pop;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mode_mem[wr_ptr[PTR_W-1:0]] <= i_mode;
      thresh_mem[wr_ptr[PTR_W-1:0]] <= i_thresh;
      lanes_mem[wr_ptr[PTR_W-1:0]] <= i_lanes;
    end
  end

  //////////////////////////////
  // pointers and strobes
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      o_beat.valid <= 1'b0;
      o_in_credit <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // freed slot goes back to the source as a credit
      o_in_credit <= pop;
      o_beat.valid <= pop;
    end
  end

  // popped beat held until the next pop
  always_ff @(posedge clk) begin
    if (pop) begin
      o_beat.mode <= mode_mem[rd_ptr[PTR_W-1:0]];
      o_beat.thresh <= thresh_mem[rd_ptr[PTR_W-1:0]];
      o_beat.lanes <= lanes_mem[rd_ptr[PTR_W-1:0]];
    end
  end

endmodule

//--- out_credit_ctl.sv
`timescale 1ns/1ns

module out_credit_ctl (
  input  logic clk,
  input  logic rst_n,
  input  logic i_popped,
  input  logic i_out_credit,
  output logic o_pop_ok
);
  import abs_cmp_pkg::*;

  // free slots at the sink
  credit_t credit_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= credit_t'(OUT_CREDITS);
    end else begin
      case ({i_popped, i_out_credit})
        // pop reserves a slot for the beat entering the pipe
        2'b10: credit_cnt <= credit_cnt - credit_t'(1);
        // returned slot, never above the reset value
        2'b01: begin
          if (credit_cnt < credit_t'(OUT_CREDITS)) begin
            credit_cnt <= credit_cnt + credit_t'(1);
          end
        end
        // pop and return together cancel
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // any free slot allows a pop
  assign o_pop_ok = (credit_cnt != '0);

endmodule

//--- abs_real.sv
`timescale 1ns/1ns

module abs_real (
  input  logic clk,
  input  logic rst_n,
  input  logic i_vld,
  input  abs_cmp_pkg::lane_t i_sample,
  output logic o_rdy,
  output abs_cmp_pkg::lane_t o_abs
);
  import abs_cmp_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rdy <= 1'b0;
    end else begin
      o_rdy <= i_vld;
    end
  end

  // read as unsigned after negation, so -32768 lands on 32768
  always_ff @(posedge clk) begin
    if (i_vld) begin
      o_abs <= i_sample[LANE_W-1] ? lane_t'(-i_sample) : i_sample;
    end
  end

endmodule

//--- abs_complex.sv
`timescale 1ns/1ns

module abs_complex #(
  parameter int WIDTH = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_vld,
  input  logic signed [WIDTH-1:0] i_re,
  input  logic signed [WIDTH-1:0] i_im,
  output logic o_rdy,
  output logic [WIDTH:0] o_mag
);

  // stage 1 part magnitudes, unsigned
  logic [WIDTH-1:0] abs_re;
  logic [WIDTH-1:0] abs_im;
  logic vld_s1;
  logic [WIDTH-1:0] max_v;
  logic [WIDTH-1:0] min_v;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_s1 <= 1'b0;
      o_rdy <= 1'b0;
    end else begin
      vld_s1 <= i_vld;
      o_rdy <= vld_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_vld) begin
      abs_re <= i_re[WIDTH-1] ? -i_re : i_re;
      abs_im <= i_im[WIDTH-1] ? -i_im : i_im;
    end
  end

  assign max_v = (abs_re > abs_im) ? abs_re : abs_im;
  assign min_v = (abs_re > abs_im) ? abs_im : abs_re;

  // stage 2, alpha-max-plus-beta-min with alpha 1 and beta 1/2
  always_ff @(posedge clk) begin
    if (vld_s1) begin
      o_mag <= {1'b0, max_v} + {2'b00, min_v[WIDTH-1:1]};
    end
  end

endmodule

//--- abs_cmp.sv
`timescale 1ns/1ns

module abs_cmp (
  input  logic clk,
  input  logic rst_n,
  beat_if.dst i_beat,
  output logic o_valid,
  output abs_cmp_pkg::mode_e o_mode,
  output abs_cmp_pkg::flags_t o_flags
);
  import abs_cmp_pkg::*;

  // divert registers, one set per lane reading
  lane_t real_smp [NUM_LANES];
  lane_t c16_re [NUM_LANES/2];
  lane_t c16_im [NUM_LANES/2];
  logic [2*LANE_W-1:0] c32_re [NUM_LANES/4];
  logic [2*LANE_W-1:0] c32_im [NUM_LANES/4];
  // per-path valids after divert
  logic s1_rvld;
  logic s1_c16vld;
  logic s1_c32vld;
  // beat fields riding alongside the data
  mode_e mode_q [CMP_LAT];
  thresh_t thresh_q [CMP_LAT];
  // abs and magnitude results
  logic [NUM_LANES-1:0] real_rdy;
  logic [NUM_LANES/2-1:0] c16_rdy;
  logic [NUM_LANES/4-1:0] c32_rdy;
  lane_t real_abs [NUM_LANES];
  lane_t real_abs_d [NUM_LANES];
  logic real_vld_d;
  mag16_t c16_mag [NUM_LANES/2];
  mag32_t c32_mag [NUM_LANES/4];
  logic mag_vld;
  flags_t real_flags;
  logic [NUM_LANES/2-1:0] c16_flags;
  logic [NUM_LANES/4-1:0] c32_flags;
  flags_t nxt_flags;

  //////////////////////////////
  // lane divert
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_rvld <= 1'b0;
      s1_c16vld <= 1'b0;
      s1_c32vld <= 1'b0;
    end else begin
      s1_rvld <= i_beat.valid && (i_beat.mode == MODE_REAL16);
      s1_c16vld <= i_beat.valid && (i_beat.mode == MODE_CPLX16);
      s1_c32vld <= i_beat.valid && (i_beat.mode == MODE_CPLX32);
    end
  end

  // only the active path loads, the others hold
  always_ff @(posedge clk) begin
    if (i_beat.valid) begin
      case (i_beat.mode)
        MODE_REAL16: begin
          for (int k = 0; k < NUM_LANES; k++) begin
            real_smp[k] <= i_beat.lanes[k];
          end
        end
        // even lane real, odd lane imaginary
        MODE_CPLX16: begin
          for (int k = 0; k < NUM_LANES/2; k++) begin
            c16_re[k] <= i_beat.lanes[2*k];
            c16_im[k] <= i_beat.lanes[2*k+1];
          end
        end
        // upper lane of each pair is the high half
        MODE_CPLX32: begin
          for (int k = 0; k < NUM_LANES/4; k++) begin
            c32_re[k] <= {i_beat.lanes[4*k+1], i_beat.lanes[4*k]};
            c32_im[k] <= {i_beat.lanes[4*k+3], i_beat.lanes[4*k+2]};
          end
        end
        default: ;
      endcase
    end
  end

  // mode and estimate follow the beat up to the compare
  always_ff @(posedge clk) begin
    mode_q[0] <= i_beat.mode;
    thresh_q[0] <= i_beat.thresh;
    for (int s = 1; s < CMP_LAT; s++) begin
      mode_q[s] <= mode_q[s-1];
      thresh_q[s] <= thresh_q[s-1];
    end
  end

  //////////////////////////////
  // abs and magnitude
  //////////////////////////////
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_real
    abs_real u_abs_real (
      .clk(clk), .rst_n(rst_n), .i_vld(s1_rvld), .i_sample(real_smp[k]),
      .o_rdy(real_rdy[k]), .o_abs(real_abs[k])
    );
  end

  for (genvar k = 0; k < NUM_LANES/2; k++) begin : g_c16
    abs_complex #(.WIDTH(LANE_W)) u_abs_c16 (
      .clk(clk), .rst_n(rst_n), .i_vld(s1_c16vld), .i_re(c16_re[k]), .i_im(c16_im[k]),
      .o_rdy(c16_rdy[k]), .o_mag(c16_mag[k])
    );
  end

  for (genvar k = 0; k < NUM_LANES/4; k++) begin : g_c32
    abs_complex #(.WIDTH(2*LANE_W)) u_abs_c32 (
      .clk(clk), .rst_n(rst_n), .i_vld(s1_c32vld), .i_re(c32_re[k]), .i_im(c32_im[k]),
      .o_rdy(c32_rdy[k]), .o_mag(c32_mag[k])
    );
  end

  // real path is one stage short of the complex path
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      real_vld_d <= 1'b0;
    end else begin
      real_vld_d <= &real_rdy;
    end
  end

  always_ff @(posedge clk) begin
    if (&real_rdy) begin
      real_abs_d <= real_abs;
    end
  end

  //////////////////////////////
  // threshold compare
  //////////////////////////////
  // quiet when not above the estimate, zero-extended to the slice width
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      real_flags[k] = (real_abs_d[k] <= thresh_q[CMP_LAT-1][LANE_W-1:0]);
    end
    for (int k = 0; k < NUM_LANES/2; k++) begin
      c16_flags[k] = ((2*LANE_W)'(c16_mag[k]) <= thresh_q[CMP_LAT-1][2*LANE_W-1:0]);
    end
    for (int k = 0; k < NUM_LANES/4; k++) begin
      c32_flags[k] = (THRESH_W'(c32_mag[k]) <= thresh_q[CMP_LAT-1]);
    end
    case (mode_q[CMP_LAT-1])
      MODE_REAL16: nxt_flags = real_flags;
      MODE_CPLX16: nxt_flags = flags_t'(c16_flags);
      MODE_CPLX32: nxt_flags = flags_t'(c32_flags);
      default:     nxt_flags = '0;
    endcase
  end

  // paths are aligned, at most one is valid per cycle
  assign mag_vld = real_vld_d | (&c16_rdy) | (&c32_rdy);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
      o_mode <= MODE_REAL16;
      o_flags <= '0;
    end else begin
      o_valid <= mag_vld;
      if (mag_vld) begin
        o_mode <= mode_q[CMP_LAT-1];
        o_flags <= nxt_flags;
      end
    end
  end

endmodule

//--- prep_top.sv
`timescale 1ns/1ns

module prep_top (
  input  logic clk,
  input  logic rst_n,
  // source side, credit governed
  input  logic i_valid,
  input  abs_cmp_pkg::mode_e i_mode,
  input  abs_cmp_pkg::thresh_t i_thresh,
  input  abs_cmp_pkg::lane_t [abs_cmp_pkg::NUM_LANES-1:0] i_lanes,
  output logic o_in_credit,
  // sink side, credits come back on i_out_credit
  output logic o_valid,
  output abs_cmp_pkg::mode_e o_mode,
  output abs_cmp_pkg::flags_t o_flags,
  input  logic i_out_credit
);

  // popped beat into the compare stage
  beat_if u_beat ();

  // pop handshake between buffer and credit counter
  logic popped;
  logic pop_ok;

  beat_fifo u_beat_fifo (
    .clk(clk),
    .rst_n(rst_n),
    .i_valid(i_valid),
    .i_mode(i_mode),
    .i_thresh(i_thresh),
    .i_lanes(i_lanes),
    .i_pop_ok(pop_ok),
    .o_popped(popped),
    .o_in_credit(o_in_credit),
    .o_beat(u_beat.src)
  );

  out_credit_ctl u_out_credit_ctl (
    .clk(clk),
    .rst_n(rst_n),
    .i_popped(popped),
    .i_out_credit(i_out_credit),
    .o_pop_ok(pop_ok)
  );

  abs_cmp u_abs_cmp (
    .clk(clk),
    .rst_n(rst_n),
    .i_beat(u_beat.dst),
    .o_valid(o_valid),
    .o_mode(o_mode),
    .o_flags(o_flags)
  );

endmodule

//--- prep_checker.sv
`timescale 1ns/1ns

module prep_checker (
  input logic clk,
  input logic rst_n,
  input logic i_valid,
  input logic i_fifo_full,
  input abs_cmp_pkg::credit_t i_credit_cnt,
  input logic i_out_valid,
  input abs_cmp_pkg::mode_e i_out_mode,
  input abs_cmp_pkg::flags_t i_out_flags
);
  import abs_cmp_pkg::*;

  //////////////////////////////
  // credit bounds
  //////////////////////////////
  // unsigned count, an underflow wraps above the limit
  a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
    i_credit_cnt <= credit_t'(OUT_CREDITS))
    else $error("downstream credit count out of range");

  // source must not write into a full buffer
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_valid && i_fifo_full))
    else $error("write into a full input buffer");

  //////////////////////////////
  // flag legality
  //////////////////////////////
  a_c16_flags: assert property (@(posedge clk) disable iff (!rst_n)
    (i_out_valid && i_out_mode == MODE_CPLX16) |-> (i_out_flags[NUM_LANES-1:4] == '0))
    else $error("flag bits above the four complex samples set");

  a_c32_flags: assert property (@(posedge clk) disable iff (!rst_n)
    (i_out_valid && i_out_mode == MODE_CPLX32) |-> (i_out_flags[NUM_LANES-1:2] == '0))
    else $error("flag bits above the two complex samples set");

endmodule

bind prep_top prep_checker u_prep_checker (
  .clk(clk),
  .rst_n(rst_n),
  .i_valid(i_valid),
  .i_fifo_full(u_beat_fifo.full),
  .i_credit_cnt(u_out_credit_ctl.credit_cnt),
  .i_out_valid(o_valid),
  .i_out_mode(o_mode),
  .i_out_flags(o_flags)
);

//--- tb_prep_top.sv
`timescale 1ns/1ns

module tb_prep_top;
  import abs_cmp_pkg::*;

  // one case is mode, threshold, eight lanes and expected flags
  localparam int NUM_CASES = 16;
  localparam int CASE_WORDS = 11;
  // sink holds results 4 to 7 this long, so pops and input credits run dry
  localparam int STALL_CYCLES = 30;
  localparam int MAX_CYCLES = 40 * NUM_CASES + 50;

  logic clk = 1'b0;
  logic rst_n;
  logic i_valid;
  mode_e i_mode;
  thresh_t i_thresh;
  lane_t [NUM_LANES-1:0] i_lanes;
  logic o_in_credit;
  logic o_valid;
  mode_e o_mode;
  flags_t o_flags;
  logic i_out_credit;

  logic [63:0] case_mem [NUM_CASES*CASE_WORDS];
  // source credits, results seen, sink release cycles
  int in_cred = DEPTH;
  int rcv_cnt = 0;
  int cycle = 0;
  int pending [$];
  logic [31:0] rnd_state = 32'd63;

  prep_top uut (
    .clk(clk), .rst_n(rst_n),
    .i_valid(i_valid), .i_mode(i_mode), .i_thresh(i_thresh), .i_lanes(i_lanes),
    .o_in_credit(o_in_credit),
    .o_valid(o_valid), .o_mode(o_mode), .o_flags(o_flags),
    .i_out_credit(i_out_credit)
  );

  always #50 clk = ~clk;

  // xorshift32 step
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  // waits for an input credit, then holds the beat for one edge
  task automatic send_beat(input int n);
    int base;
    base = n * CASE_WORDS;
    while (in_cred == 0) begin
      i_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    i_valid = 1'b1;
    i_mode = mode_e'(case_mem[base][1:0]);
    i_thresh = case_mem[base+1];
    for (int k = 0; k < NUM_LANES; k++) begin
      i_lanes[k] = case_mem[base+2+k][LANE_W-1:0];
    end
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////
  // credits and timeout
  //////////////////////////////
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > MAX_CYCLES) begin
      abort_run("timeout, not every result came back");
    end
  end

  // source side bookkeeping, mid-cycle when everything is settled
  always @(negedge clk) begin
    if (!rst_n) begin
      in_cred = DEPTH;
    end else begin
      in_cred = in_cred - int'(i_valid) + int'(o_in_credit);
      // a credit pulse with no beat behind it
      assert (in_cred <= DEPTH) else
        abort_run("input credit returned without a beat in the buffer");
    end
  end

  // sink hands back one credit per cycle once its hold time is up
  always @(posedge clk) begin
    #1;
    if (pending.size() > 0 && pending[0] <= cycle) begin
      void'(pending.pop_front());
      i_out_credit = 1'b1;
    end else begin
      i_out_credit = 1'b0;
    end
  end

  //////////////////////////////
  // result checks
  //////////////////////////////
  always @(negedge clk) begin : check_results
    int base;
    int hold;
    if (rst_n && o_valid) begin
      assert (rcv_cnt < NUM_CASES) else abort_run("result seen after the last case");
      base = rcv_cnt * CASE_WORDS;
      assert (o_mode == mode_e'(case_mem[base][1:0])) else
        abort_run($sformatf("Mismatch at %0t ns: result %0d mode %0d, expected %0d",
                            $time, rcv_cnt, o_mode, case_mem[base][1:0]));
      assert (o_flags == case_mem[base+CASE_WORDS-1][NUM_LANES-1:0]) else
        abort_run($sformatf("Mismatch at %0t ns: result %0d flags %02h, expected %02h",
                            $time, rcv_cnt, o_flags,
                            case_mem[base+CASE_WORDS-1][NUM_LANES-1:0]));
      rnd_state = next_rand(rnd_state);
      hold = (rcv_cnt >= 4 && rcv_cnt < 8) ? STALL_CYCLES : int'(rnd_state[1:0]);
      pending.push_back(cycle + 1 + hold);
      assert (pending.size() <= OUT_CREDITS) else
        abort_run("more results held at the sink than downstream credits");
      rcv_cnt = rcv_cnt + 1;
    end
  end

  initial begin
    rst_n = 1'b0;
    i_valid = 1'b0;
    i_mode = MODE_REAL16;
    i_thresh = '0;
    i_lanes = '0;
    i_out_credit = 1'b0;
    $readmemh("prep_cases.txt", case_mem);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // back to back while credits last
    for (int n = 0; n < NUM_CASES; n++) begin
      send_beat(n);
    end
    i_valid = 1'b0;
    wait (rcv_cnt == NUM_CASES);
    // idle tail catches stray results and late credits
    repeat (10) @(posedge clk);
    if (pending.size() == 0 && in_cred == DEPTH) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("credits were not all returned at the end of the run");
    end
  end

endmodule

//--- prep_cases.txt
// mode threshold lane0 lane1 lane2 lane3 lane4 lane5 lane6 lane7 expected_flags
// mode 0 real16, 1 cplx16, 2 cplx32; flag bit k belongs to sample k
0 0000000000000100 0000 8000 0100 FF00 0101 FEFF 7FFF FFFF 8D
1 0000000000000064 0050 0028 FFB0 0029 002A FFB0 0000 0065 03
2 0000000000018000 0000 0001 8000 0000 0000 FFFF 0002 0001 01
0 0000000000008000 8000 7FFF 8001 0000 1234 EDCC 4000 C000 FF
1 000000000000BFFF 8000 8000 8000 8001 7FFF 7FFF 8000 7FFF 0E
2 00000000BFFFFFFF 0000 8000 0000 8000 FFFF 7FFF 0000 0000 02
0 0000000000000000 0000 0001 FFFF 0000 8000 0000 0002 0000 A9
1 0000000000000000 0000 0000 0000 0001 0001 0000 FFFF FFFF 01
2 0000000000000000 0000 0000 0000 0000 0001 0000 0000 0000 01
0 0000000000000010 0010 0011 FFF0 FFEF 0005 0020 FFFB 0000 D5
1 000000000000000A 0008 0004 FFF8 FFFB 0009 0003 000A 0002 07
2 0000000000000003 0002 0000 0002 0000 FFFD FFFF 0002 0000 01
0 0000000000007FFF 8000 7FFF 8001 0000 FFFF 4000 C000 8000 7E
1 0000000000010000 8000 0000 8000 8000 7FFF 8000 0001 0001 0F
0 0000000000000003 0003 0004 FFFD FFFC 0000 0001 0002 0005 75
2 FFFFFFFFFFFFFFFF 1234 5678 9ABC DEF0 1111 2222 3333 4444 03

//--- all.f
abs_cmp_pkg.sv
beat_if.sv
beat_fifo.sv
out_credit_ctl.sv
abs_real.sv
abs_complex.sv
abs_cmp.sv
prep_top.sv
prep_checker.sv
tb_prep_top.sv

//--- run.sh
#!/bin/bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_prep_top -f all.f -o sim_prep \
  && ./obj_dir/sim_prep | tee sim.log \
  && grep -q "all tests passed" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
